// ==== dec_stage.f ====
+incdir+dv
src/rv_isa_pkg.sv
src/dec_pkg.sv
src/instr_decoder.sv
src/imm_gen.sv
src/gprs.sv
src/issue_reg.sv
src/dec_stage.sv
dv/dec_stage_tb.sv

// ==== dv/dec_tb_vectors.svh ====
/*
 Stimulus rows, one per clock. the columns are instr, pc, {if_valid, ex_ready, flush},
 write-back enable and write-back rd. write-back data comes from $random at apply time.
 rows under ex_ready low repeat the same instr and pc, as fetch must hold them.
*/

task automatic load_table;
	// preload x1..x5 under bubbles
	add_row(32'h0000_0000, 32'h0100, 3'b010, 1'b1, 5'd1);
	add_row(32'h0000_0000, 32'h0100, 3'b010, 1'b1, 5'd2);
	add_row(32'h0000_0000, 32'h0100, 3'b010, 1'b1, 5'd3);
	add_row(32'h0000_0000, 32'h0100, 3'b010, 1'b1, 5'd4);
	add_row(32'h0000_0000, 32'h0100, 3'b010, 1'b1, 5'd5);
	// add sub slt sltu xor or and sll srl sra on registers
	add_row(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd10), 32'h1000, 3'b110, 1'b0, 5'd0);
	add_row(r_type(7'h20, 5'd4, 5'd3, 3'b000, 5'd11), 32'h1004, 3'b110, 1'b0, 5'd0);
	add_row(r_type(7'h00, 5'd5, 5'd1, 3'b010, 5'd12), 32'h1008, 3'b110, 1'b0, 5'd0);
	add_row(r_type(7'h00, 5'd1, 5'd5, 3'b011, 5'd13), 32'h100c, 3'b110, 1'b0, 5'd0);
	add_row(r_type(7'h00, 5'd3, 5'd2, 3'b100, 5'd14), 32'h1010, 3'b110, 1'b0, 5'd0);
	add_row(r_type(7'h00, 5'd5, 5'd4, 3'b110, 5'd15), 32'h1014, 3'b110, 1'b0, 5'd0);
	add_row(r_type(7'h00, 5'd3, 5'd1, 3'b111, 5'd16), 32'h1018, 3'b110, 1'b0, 5'd0);
	add_row(r_type(7'h00, 5'd4, 5'd2, 3'b001, 5'd17), 32'h101c, 3'b110, 1'b0, 5'd0);
	add_row(r_type(7'h00, 5'd1, 5'd3, 3'b101, 5'd18), 32'h1020, 3'b110, 1'b0, 5'd0);
	add_row(r_type(7'h20, 5'd1, 5'd3, 3'b101, 5'd19), 32'h1024, 3'b110, 1'b0, 5'd0);
	// x0 as source while a write to x0 is attempted
	add_row(r_type(7'h00, 5'd2, 5'd0, 3'b000, 5'd20), 32'h1028, 3'b110, 1'b1, 5'd0);
	// addi slti sltiu xori slli srli srai
	add_row(i_type(12'hffb, 5'd1, 3'b000, 5'd21, OPC_OP_IMM), 32'h102c, 3'b110, 1'b0, 5'd0);
	add_row(i_type(12'h7ff, 5'd2, 3'b010, 5'd22, OPC_OP_IMM), 32'h1030, 3'b110, 1'b0, 5'd0);
	add_row(i_type(12'h800, 5'd3, 3'b011, 5'd23, OPC_OP_IMM), 32'h1034, 3'b110, 1'b0, 5'd0);
	add_row(i_type(12'hf0f, 5'd4, 3'b100, 5'd24, OPC_OP_IMM), 32'h1038, 3'b110, 1'b0, 5'd0);
	add_row(i_type(12'h003, 5'd2, 3'b001, 5'd27, OPC_OP_IMM), 32'h103c, 3'b110, 1'b0, 5'd0);
	add_row(i_type(12'h01f, 5'd3, 3'b101, 5'd28, OPC_OP_IMM), 32'h1040, 3'b110, 1'b0, 5'd0);
	add_row(i_type(12'h41f, 5'd3, 3'b101, 5'd29, OPC_OP_IMM), 32'h1044, 3'b110, 1'b0, 5'd0);
	// lb, lhu, lw
	add_row(i_type(12'hffc, 5'd1, 3'b000, 5'd6, OPC_LOAD), 32'h1048, 3'b110, 1'b0, 5'd0);
	add_row(i_type(12'h008, 5'd2, 3'b101, 5'd7, OPC_LOAD), 32'h104c, 3'b110, 1'b0, 5'd0);
	add_row(i_type(12'h7fc, 5'd3, 3'b010, 5'd8, OPC_LOAD), 32'h1050, 3'b110, 1'b0, 5'd0);
	// sb, sh, sw
	add_row(s_type(12'hfff, 5'd2, 5'd1, 3'b000), 32'h1054, 3'b110, 1'b0, 5'd0);
	add_row(s_type(12'h010, 5'd3, 5'd4, 3'b001), 32'h1058, 3'b110, 1'b0, 5'd0);
	add_row(s_type(12'h800, 5'd5, 5'd2, 3'b010), 32'h105c, 3'b110, 1'b0, 5'd0);
	// beq bne blt bge bltu bgeu with both offset signs
	add_row(b_type(13'h0008, 5'd2, 5'd1, 3'b000), 32'h1060, 3'b110, 1'b0, 5'd0);
	add_row(b_type(13'h1ff0, 5'd4, 5'd3, 3'b001), 32'h1064, 3'b110, 1'b0, 5'd0);
	add_row(b_type(13'h0ffe, 5'd1, 5'd5, 3'b100), 32'h1068, 3'b110, 1'b0, 5'd0);
	add_row(b_type(13'h1000, 5'd3, 5'd2, 3'b101), 32'h106c, 3'b110, 1'b0, 5'd0);
	add_row(b_type(13'h0020, 5'd5, 5'd4, 3'b110), 32'h1070, 3'b110, 1'b0, 5'd0);
	add_row(b_type(13'h1ffe, 5'd1, 5'd1, 3'b111), 32'h1074, 3'b110, 1'b0, 5'd0);
	// lui, auipc, jal back and forward, jalr
	add_row(u_type(20'habcde, 5'd11, OPC_LUI), 32'h1078, 3'b110, 1'b0, 5'd0);
	add_row(u_type(20'h80001, 5'd12, OPC_AUIPC), 32'h107c, 3'b110, 1'b0, 5'd0);
	add_row(j_type(21'h1ff800, 5'd1), 32'h1080, 3'b110, 1'b0, 5'd0);
	add_row(j_type(21'h0ffffe, 5'd13), 32'h1084, 3'b110, 1'b0, 5'd0);
	add_row(i_type(12'h00c, 5'd3, 3'b000, 5'd14, OPC_JALR), 32'h1088, 3'b110, 1'b0, 5'd0);
	// the sub waits three cycles under back-pressure and is taken once
	add_row(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd15), 32'h108c, 3'b110, 1'b0, 5'd0);
	add_row(r_type(7'h20, 5'd1, 5'd3, 3'b000, 5'd16), 32'h1090, 3'b100, 1'b0, 5'd0);
	add_row(r_type(7'h20, 5'd1, 5'd3, 3'b000, 5'd16), 32'h1090, 3'b100, 1'b0, 5'd0);
	add_row(r_type(7'h20, 5'd1, 5'd3, 3'b000, 5'd16), 32'h1090, 3'b100, 1'b0, 5'd0);
	add_row(r_type(7'h20, 5'd1, 5'd3, 3'b000, 5'd16), 32'h1090, 3'b110, 1'b0, 5'd0);
	// bubble, then flush over a valid slot with ex_ready low and with ex_ready high
	add_row(r_type(7'h00, 5'd3, 5'd2, 3'b100, 5'd9), 32'h1094, 3'b010, 1'b0, 5'd0);
	add_row(r_type(7'h00, 5'd5, 5'd4, 3'b110, 5'd9), 32'h1098, 3'b110, 1'b0, 5'd0);
	add_row(r_type(7'h00, 5'd3, 5'd1, 3'b111, 5'd9), 32'h109c, 3'b101, 1'b0, 5'd0);
	add_row(r_type(7'h00, 5'd3, 5'd1, 3'b111, 5'd9), 32'h109c, 3'b110, 1'b0, 5'd0);
	add_row(r_type(7'h00, 5'd1, 5'd4, 3'b001, 5'd9), 32'h10a0, 3'b111, 1'b0, 5'd0);
	// write-back in the same cycle as the read of rs1, rs2 and store data
	add_row(r_type(7'h00, 5'd2, 5'd6, 3'b000, 5'd17), 32'h10a4, 3'b110, 1'b1, 5'd6);
	add_row(r_type(7'h20, 5'd7, 5'd1, 3'b000, 5'd18), 32'h10a8, 3'b110, 1'b1, 5'd7);
	add_row(s_type(12'h004, 5'd8, 5'd1, 3'b010), 32'h10ac, 3'b110, 1'b1, 5'd8);
	add_row(32'h0000_0000, 32'h10b0, 3'b010, 1'b0, 5'd0);
endtask

// ==== dv/dec_stage_tb.sv ====
/*
 Testbench for dec_stage with 32 registers. one table row is applied per clock.
 a register model and a decode model predict ex_ctrl one edge later.
*/
`timescale 1ns/1ps

module dec_stage_tb;
	import rv_isa_pkg::*;
	import dec_pkg::*;

	localparam int NUM_REGS = 32;
	localparam int RESET_TIMEOUT = 64; // cycles

	// opcodes as the ISA manual lists them
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;

	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] pc;
		logic [2:0]  hs; // if_valid, ex_ready, flush
		logic        wb_we;
		reg_idx_t    wb_rd;
	} row_t;

	typedef struct packed {
		logic     valid;
		ex_ctrl_t ctrl;
	} expect_t;

	logic        cpu_clk;
	logic        cpu_rstn;
	logic        if_valid;
	logic [31:0] instr;
	logic [31:0] pc;
	logic        dec_ready;
	logic        ex_ready;
	logic        flush;
	wb_req_t     wb;
	logic        dec_valid;
	ex_ctrl_t    ex_ctrl;

	row_t        rows[$];
	expect_t     pending[$]; // holds one entry until the next edge
	expect_t     state;      // what the issue register should hold
	logic [31:0] model_regs [0:31];
	integer      seed;

	dec_stage #(
		.NUM_REGS (NUM_REGS)
	) u_dec_stage (
		.cpu_clk   (cpu_clk),
		.cpu_rstn  (cpu_rstn),
		.if_valid  (if_valid),
		.instr     (instr),
		.pc        (pc),
		.dec_ready (dec_ready),
		.ex_ready  (ex_ready),
		.flush     (flush),
		.wb        (wb),
		.dec_valid (dec_valid),
		.ex_ctrl   (ex_ctrl)
	);

	always #20 cpu_clk = ~cpu_clk;

	initial
	begin
		cpu_rstn = 1'b0;
		repeat (16) @(posedge cpu_clk);
		#2 cpu_rstn = 1'b1;
	end

	function automatic logic [31:0] r_type(input logic [6:0] f7, input reg_idx_t rs2,
		input reg_idx_t rs1, input logic [2:0] f3, input reg_idx_t rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input reg_idx_t rs1,
		input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input reg_idx_t rs2,
		input reg_idx_t rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] off, input reg_idx_t rs2,
		input reg_idx_t rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] upper, input reg_idx_t rd,
		input logic [6:0] opc);
		return {upper, rd, opc};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] off, input reg_idx_t rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
	endfunction

	function automatic alu_op_e alu_for_funct(input logic [2:0] f3, input logic alt,
		input logic reg_form);
		alu_op_e op;

		case (f3)
			3'b000:  op = (reg_form && alt) ? ALU_SUB : ALU_ADD; // addi never subtracts
			3'b001:  op = ALU_SLL;
			3'b010:  op = ALU_SLT;
			3'b011:  op = ALU_SLTU;
			3'b100:  op = ALU_XOR;
			3'b101:  op = alt ? ALU_SRA : ALU_SRL;
			3'b110:  op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	function automatic ex_ctrl_t decode_model(input logic [31:0] ins, input logic [31:0] at_pc);
		ex_ctrl_t    e;
		logic [2:0]  f3;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] imm_u;
		logic [31:0] imm_j;

		f3 = ins[14:12];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_u = {ins[31:12], 12'h000};
		imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		e = '0;
		e.rd = ins[11:7];
		e.pc = at_pc;
		e.src1 = model_regs[ins[19:15]];
		e.src2 = model_regs[ins[24:20]];
		e.store_data = model_regs[ins[24:20]];
		case (ins[6:0])
			OPC_OP:
			begin
				e.alu_op = alu_for_funct(f3, ins[30], 1'b1);
				e.rd_we = 1'b1;
			end
			OPC_OP_IMM:
			begin
				e.alu_op = alu_for_funct(f3, ins[30], 1'b0);
				e.imm = imm_i;
				e.src2 = imm_i;
				e.rd_we = 1'b1;
			end
			OPC_LOAD, OPC_STORE:
			begin
				e.alu_op = ALU_ADD; // address
				e.imm = (ins[6:0] == OPC_LOAD) ? imm_i : imm_s;
				e.src2 = e.imm;
				e.mem.load = (ins[6:0] == OPC_LOAD);
				e.mem.store = (ins[6:0] == OPC_STORE);
				e.mem.size = (f3[1:0] == 2'b00) ? MEM_BYTE :
					(f3[1:0] == 2'b01) ? MEM_HALF : MEM_WORD;
				e.mem.is_unsigned = e.mem.load && f3[2];
				e.rd_we = e.mem.load;
			end
			OPC_BRANCH:
			begin
				e.imm = imm_b;
				case (f3)
					3'b000:  e.branch_op = BR_EQ;
					3'b001:  e.branch_op = BR_NE;
					3'b100:  e.branch_op = BR_LT;
					3'b101:  e.branch_op = BR_GE;
					3'b110:  e.branch_op = BR_LTU;
					default: e.branch_op = BR_GEU;
				endcase
				e.alu_op = f3[2] ? (f3[1] ? ALU_SLTU : ALU_SLT) : ALU_SUB;
			end
			OPC_LUI, OPC_AUIPC:
			begin
				e.alu_op = (ins[6:0] == OPC_AUIPC) ? ALU_ADD : ALU_NONE;
				e.imm = imm_u;
				e.src1 = (ins[6:0] == OPC_AUIPC) ? at_pc : 32'h0;
				e.src2 = imm_u;
				e.rd_we = 1'b1;
			end
			OPC_JAL, OPC_JALR:
			begin
				e.jalr = (ins[6:0] == OPC_JALR);
				e.imm = e.jalr ? imm_i : imm_j;
				e.src1 = e.jalr ? e.src1 : 32'h0;
				e.src2 = at_pc + 32'd4; // link address
				e.rd_we = 1'b1;
			end
			default: e.rd = ins[11:7];
		endcase
		return e;
	endfunction

	// bubble or flush keeps the data fields
	function automatic ex_ctrl_t clear_controls(input ex_ctrl_t c);
		ex_ctrl_t k;

		k = c;
		k.alu_op = ALU_NONE;
		k.branch_op = BR_NONE;
		k.mem = '0;
		k.jalr = 1'b0;
		k.rd_we = 1'b0;
		return k;
	endfunction

	task automatic add_row(input logic [31:0] ins, input logic [31:0] at_pc,
		input logic [2:0] hs, input logic wb_we, input reg_idx_t wb_rd);
		row_t r;

		r.instr = ins;
		r.pc = at_pc;
		r.hs = hs;
		r.wb_we = wb_we;
		r.wb_rd = wb_rd;
		rows.push_back(r);
	endtask

	`include "dec_tb_vectors.svh"

	task automatic check_value(input string field, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, field, actual, expected);
			$display("Simulation FAILED");
			$fatal(1, "output mismatch");
		end
	endtask

	task automatic check_outputs;
		expect_t e;

		if (pending.size() == 0)
		begin
			$display("no expected value was queued before the check");
			$display("Simulation FAILED");
			$fatal(1, "empty expectation queue");
		end
		e = pending.pop_front();
		check_value("dec_ready", 32'(dec_ready), 32'(ex_ready));
		check_value("dec_valid", 32'(dec_valid), 32'(e.valid));
		check_value("alu_op", 32'(ex_ctrl.alu_op), 32'(e.ctrl.alu_op));
		check_value("branch_op", 32'(ex_ctrl.branch_op), 32'(e.ctrl.branch_op));
		check_value("mem", 32'(ex_ctrl.mem), 32'(e.ctrl.mem));
		check_value("jalr", 32'(ex_ctrl.jalr), 32'(e.ctrl.jalr));
		check_value("rd", 32'(ex_ctrl.rd), 32'(e.ctrl.rd));
		check_value("rd_we", 32'(ex_ctrl.rd_we), 32'(e.ctrl.rd_we));
		check_value("src1", ex_ctrl.src1, e.ctrl.src1);
		check_value("src2", ex_ctrl.src2, e.ctrl.src2);
		check_value("store_data", ex_ctrl.store_data, e.ctrl.store_data);
		check_value("imm", ex_ctrl.imm, e.ctrl.imm);
		check_value("pc", ex_ctrl.pc, e.ctrl.pc);
	endtask

	task automatic apply_row(input row_t r);
		logic [31:0] data;

		data = '0;
		if (r.wb_we)
			data = $random(seed);
		{if_valid, ex_ready, flush} = r.hs;
		instr = r.instr;
		pc = r.pc;
		wb.we = r.wb_we;
		wb.rd = r.wb_rd;
		wb.data = data;
		// lands at the next edge, but reads in this cycle already see it
		if (r.wb_we && r.wb_rd != 5'd0 && int'(r.wb_rd) < NUM_REGS)
			model_regs[r.wb_rd] = data;
		if (r.hs[0])
		begin
			state.valid = 1'b0;
			state.ctrl = clear_controls(state.ctrl);
		end
		else if (r.hs[1])
		begin
			state.valid = r.hs[2];
			state.ctrl = r.hs[2] ? decode_model(r.instr, r.pc) : clear_controls(state.ctrl);
		end
		pending.push_back(state);
	endtask

	task automatic wait_for_reset;
		int cycles;

		cycles = 0;
		while (cpu_rstn !== 1'b1)
		begin
			if (cycles == RESET_TIMEOUT)
			begin
				$display("timed out waiting for reset to be released");
				$display("Simulation FAILED");
				$fatal(1, "reset timeout");
			end
			@(posedge cpu_clk or posedge cpu_rstn);
			cycles++;
		end
	endtask

	initial
	begin
		seed = 80364;
		cpu_clk = 1'b0;
		if_valid = 1'b0;
		ex_ready = 1'b1;
		flush = 1'b0;
		instr = '0;
		pc = '0;
		wb = '0;
		state = '0;
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		load_table();
		wait_for_reset();
		#1;
		pending.push_back(state); // reset values before any edge out of reset
		check_outputs();
		@(posedge cpu_clk); // first edge out of reset takes a bubble
		#1;
		foreach (rows[i])
		begin
			#1;
			apply_row(rows[i]);
			@(posedge cpu_clk);
			#1;
			check_outputs();
		end
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the dec_stage testbench with Verilator
# a $fatal in the testbench makes the simulation binary exit non-zero
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module dec_stage_tb -Mdir obj_dir -f dec_stage.f
./obj_dir/Vdec_stage_tb

// ==== src/dec_pkg.sv ====
/*
 Decoded control types shared by the decode modules and handed to EX.
 every "none" encoding is all zeros, so a cleared struct is a bubble.
*/

package dec_pkg;

	typedef enum logic [3:0] {
		ALU_NONE, // EX passes src2 through
		ALU_ADD,
		ALU_SUB,
		ALU_SLT,
		ALU_SLTU,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE,
		BR_EQ,
		BR_NE,
		BR_LT,
		BR_GE,
		BR_LTU,
		BR_GEU
	} branch_op_e;

	// matches funct3[1:0] of loads and stores
	typedef enum logic [1:0] {
		MEM_BYTE = 2'b00,
		MEM_HALF = 2'b01,
		MEM_WORD = 2'b10
	} mem_size_e;

	typedef enum logic [2:0] {
		IMM_NONE,
		IMM_I,
		IMM_S,
		IMM_B,
		IMM_U,
		IMM_J
	} imm_fmt_e;

	typedef enum logic [1:0] {
		SRC1_REG,
		SRC1_PC,
		SRC1_ZERO
	} src1_sel_e;

	typedef enum logic [1:0] {
		SRC2_REG,
		SRC2_IMM,
		SRC2_PC4
	} src2_sel_e;

	typedef struct packed {
		logic      load;
		logic      store;
		mem_size_e size;
		logic      is_unsigned; // zero extend on load
	} mem_ctrl_t;

	typedef struct packed {
		alu_op_e    alu_op;
		branch_op_e branch_op;
		mem_ctrl_t  mem;
		imm_fmt_e   imm_fmt;
		src1_sel_e  src1_sel;
		src2_sel_e  src2_sel;
		logic       rd_we;
		logic       jalr;
	} dec_ctrl_t;

	typedef struct packed {
		alu_op_e                        alu_op;
		branch_op_e                     branch_op;
		mem_ctrl_t                      mem;
		logic                           jalr;
		rv_isa_pkg::reg_idx_t           rd;
		logic                           rd_we;
		logic [rv_isa_pkg::XLEN-1:0]    src1;
		logic [rv_isa_pkg::XLEN-1:0]    src2;
		logic [rv_isa_pkg::XLEN-1:0]    store_data;
		logic [rv_isa_pkg::XLEN-1:0]    imm;
		logic [rv_isa_pkg::XLEN-1:0]    pc;
	} ex_ctrl_t;

	typedef struct packed {
		logic                           we;
		rv_isa_pkg::reg_idx_t           rd;
		logic [rv_isa_pkg::XLEN-1:0]    data;
	} wb_req_t;

endpackage

// ==== src/dec_stage.sv ====
/*
 Decode stage top. No hazard logic, so the stage never stalls on its own.
 fetch must hold instr and pc while dec_ready is low.
*/
`timescale 1ns/1ps

module dec_stage #(
	parameter int NUM_REGS = 32 // 16 for an RV32E register file
) (
	input  logic                        cpu_clk,
	input  logic                        cpu_rstn,
	input  logic                        if_valid,
	input  rv_isa_pkg::instr_u          instr,
	input  logic [rv_isa_pkg::XLEN-1:0] pc,
	output logic                        dec_ready,
	input  logic                        ex_ready,
	input  logic                        flush,
	input  dec_pkg::wb_req_t            wb,
	output logic                        dec_valid,
	output dec_pkg::ex_ctrl_t           ex_ctrl
);
	import rv_isa_pkg::*;
	import dec_pkg::*;

	dec_ctrl_t       ctrl;
	logic [XLEN-1:0] imm;
	logic [XLEN-1:0] rs1_data;
	logic [XLEN-1:0] rs2_data;

	assign dec_ready = ex_ready;

	instr_decoder u_instr_decoder (
		.instr (instr),
		.ctrl  (ctrl)
	);

	imm_gen u_imm_gen (
		.instr   (instr),
		.imm_fmt (ctrl.imm_fmt),
		.imm     (imm)
	);

	gprs #(
		.NUM_REGS (NUM_REGS)
	) u_gprs (
		.cpu_clk  (cpu_clk),
		.cpu_rstn (cpu_rstn),
		.wb       (wb),
		.rs1      (instr.r.rs1), // don't care for U and J, src1 not read
		.rs2      (instr.r.rs2),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	issue_reg u_issue_reg (
		.cpu_clk   (cpu_clk),
		.cpu_rstn  (cpu_rstn),
		.if_valid  (if_valid),
		.ex_ready  (ex_ready),
		.flush     (flush),
		.ctrl      (ctrl),
		.imm       (imm),
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data),
		.pc        (pc),
		.rd        (instr.r.rd),
		.dec_valid (dec_valid),
		.ex_ctrl   (ex_ctrl)
	);

endmodule

// ==== src/gprs.sv ====
/*
 General purpose registers, two read ports and one write port.
 x0 and indices at or above NUM_REGS read zero and drop writes.
 a write in flight is bypassed to a same-cycle read of that index.
*/
`timescale 1ns/1ps

module gprs #(
	parameter int NUM_REGS = 32
) (
	input  logic                        cpu_clk,
	input  logic                        cpu_rstn,
	input  dec_pkg::wb_req_t            wb,
	input  rv_isa_pkg::reg_idx_t        rs1,
	input  rv_isa_pkg::reg_idx_t        rs2,
	output logic [rv_isa_pkg::XLEN-1:0] rs1_data,
	output logic [rv_isa_pkg::XLEN-1:0] rs2_data
);
	import rv_isa_pkg::*;

	logic [XLEN-1:0] regs [1:NUM_REGS-1]; // no storage for x0
	logic            wr_en;

	assign wr_en = wb.we && (wb.rd != '0) && (int'(wb.rd) < NUM_REGS);

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			for (int i = 1; i < NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (wr_en)
		begin
			regs[wb.rd] <= wb.data;
		end
	end

	function automatic logic [XLEN-1:0] read_port(input reg_idx_t idx);
		logic [XLEN-1:0] val;

		if (idx == '0 || int'(idx) >= NUM_REGS)
			val = '0;
		else if (wr_en && (wb.rd == idx))
			val = wb.data; // bypass
		else
			val = regs[idx];
		return val;
	endfunction

	always_comb
	begin
		rs1_data = read_port(rs1);
		rs2_data = read_port(rs2);
	end

endmodule

// ==== src/imm_gen.sv ====
/*
 Immediate builder for the I, S, B, U and J layouts.
 IMM_NONE returns zero; B and J offsets always have bit 0 clear.
*/
`timescale 1ns/1ps

module imm_gen (
	input  rv_isa_pkg::instr_u          instr,
	input  dec_pkg::imm_fmt_e           imm_fmt,
	output logic [rv_isa_pkg::XLEN-1:0] imm
);
	import dec_pkg::*;

	always_comb
	begin
		case (imm_fmt)
			IMM_I:
				imm = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
			IMM_S:
				imm = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
			IMM_B: // branch offset, halfword aligned
				imm = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
					instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
			IMM_U:
				imm = {instr.u.imm_31_12, 12'b0};
			IMM_J:
				imm = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
					instr.j.imm_11, instr.j.imm_10_1, 1'b0};
			default:
				imm = '0; // R-type and unknown
		endcase
	end

endmodule

// ==== src/instr_decoder.sv ====
/*
 Combinational RV32I decoder, base integer set only.
 unknown opcodes decode to a bubble with rd_we low; bad funct7 gives ALU_NONE.
 lui, jal and jalr leave alu_op at none and rely on src2 passing through.
*/
`timescale 1ns/1ps

module instr_decoder (
	input  rv_isa_pkg::instr_u  instr,
	output dec_pkg::dec_ctrl_t  ctrl
);
	import rv_isa_pkg::*;
	import dec_pkg::*;

	logic [2:0] funct3;
	logic [6:0] funct7;

	assign funct3 = instr.r.funct3; // same bit position in every layout
	assign funct7 = instr.r.funct7;

	// shared by op and op-imm, reg_form picks whether funct7 must be clean
	function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic [6:0] f7,
		input logic reg_form);
		alu_op_e op;
		logic    plain;

		op = ALU_NONE;
		plain = !reg_form || (f7 == FUNCT7_BASE);
		case (f3)
			F3_ADD:
			begin
				if (plain)
					op = ALU_ADD;
				else if (f7 == FUNCT7_ALT)
					op = ALU_SUB;
			end
			F3_SLL:  op = (f7 == FUNCT7_BASE) ? ALU_SLL : ALU_NONE; // slli too
			F3_SLT:  op = plain ? ALU_SLT : ALU_NONE;
			F3_SLTU: op = plain ? ALU_SLTU : ALU_NONE;
			F3_XOR:  op = plain ? ALU_XOR : ALU_NONE;
			F3_OR:   op = plain ? ALU_OR : ALU_NONE;
			F3_AND:  op = plain ? ALU_AND : ALU_NONE;
			F3_SR:
			begin
				if (f7 == FUNCT7_BASE)
					op = ALU_SRL;
				else if (f7 == FUNCT7_ALT)
					op = ALU_SRA;
			end
			default: op = ALU_NONE;
		endcase
		return op;
	endfunction

	always_comb
	begin
		ctrl = '0; // none everywhere, both sources from registers
		case (instr.r.opcode)
			OP_LUI:
			begin
				ctrl.imm_fmt = IMM_U;
				ctrl.src1_sel = SRC1_ZERO;
				ctrl.src2_sel = SRC2_IMM;
				ctrl.rd_we = 1'b1;
			end
			OP_AUIPC:
			begin
				ctrl.alu_op = ALU_ADD;
				ctrl.imm_fmt = IMM_U;
				ctrl.src1_sel = SRC1_PC;
				ctrl.src2_sel = SRC2_IMM;
				ctrl.rd_we = 1'b1;
			end
			OP_JAL:
			begin
				ctrl.imm_fmt = IMM_J;
				ctrl.src1_sel = SRC1_ZERO;
				ctrl.src2_sel = SRC2_PC4; // link value
				ctrl.rd_we = 1'b1;
			end
			OP_JALR:
			begin
				ctrl.imm_fmt = IMM_I;
				ctrl.src2_sel = SRC2_PC4;
				ctrl.rd_we = 1'b1;
				ctrl.jalr = 1'b1;
			end
			OP_BRANCH:
			begin
				ctrl.imm_fmt = IMM_B;
				case (funct3)
					F3_BEQ:  ctrl.branch_op = BR_EQ;
					F3_BNE:  ctrl.branch_op = BR_NE;
					F3_BLT:  ctrl.branch_op = BR_LT;
					F3_BGE:  ctrl.branch_op = BR_GE;
					F3_BLTU: ctrl.branch_op = BR_LTU;
					F3_BGEU: ctrl.branch_op = BR_GEU;
					default: ctrl.branch_op = BR_NONE;
				endcase
				// compare flavour shared by each condition pair
				case (funct3[2:1])
					2'b00:   ctrl.alu_op = ALU_SUB;
					2'b10:   ctrl.alu_op = ALU_SLT;
					2'b11:   ctrl.alu_op = ALU_SLTU;
					default: ctrl.alu_op = ALU_NONE;
				endcase
			end
			OP_LOAD:
			begin
				ctrl.alu_op = ALU_ADD; // address
				ctrl.imm_fmt = IMM_I;
				ctrl.src2_sel = SRC2_IMM;
				ctrl.mem.load = 1'b1;
				ctrl.mem.size = mem_size_e'(funct3[1:0]);
				ctrl.mem.is_unsigned = funct3[2];
				ctrl.rd_we = 1'b1;
			end
			OP_STORE:
			begin
				ctrl.alu_op = ALU_ADD;
				ctrl.imm_fmt = IMM_S;
				ctrl.src2_sel = SRC2_IMM;
				ctrl.mem.store = 1'b1;
				ctrl.mem.size = mem_size_e'(funct3[1:0]);
			end
			OP_ALU_IR:
			begin
				ctrl.alu_op = alu_decode(funct3, funct7, 1'b0);
				ctrl.imm_fmt = IMM_I;
				ctrl.src2_sel = SRC2_IMM;
				ctrl.rd_we = 1'b1;
			end
			OP_ALU_RR:
			begin
				ctrl.alu_op = alu_decode(funct3, funct7, 1'b1);
				ctrl.rd_we = 1'b1;
			end
			default: ctrl = '0;
		endcase
	end

endmodule

// ==== src/issue_reg.sv ====
/*
 Operand select and the DEC to EX pipeline register.
 flush beats ex_ready; a flush or bubble clears the control fields
 and leaves the data fields at their last values.
*/
`timescale 1ns/1ps

module issue_reg (
	input  logic                        cpu_clk,
	input  logic                        cpu_rstn,
	input  logic                        if_valid,
	input  logic                        ex_ready,
	input  logic                        flush,
	input  dec_pkg::dec_ctrl_t          ctrl,
	input  logic [rv_isa_pkg::XLEN-1:0] imm,
	input  logic [rv_isa_pkg::XLEN-1:0] rs1_data,
	input  logic [rv_isa_pkg::XLEN-1:0] rs2_data,
	input  logic [rv_isa_pkg::XLEN-1:0] pc,
	input  rv_isa_pkg::reg_idx_t        rd,
	output logic                        dec_valid,
	output dec_pkg::ex_ctrl_t           ex_ctrl
);
	import rv_isa_pkg::*;
	import dec_pkg::*;

	logic [XLEN-1:0] src1;
	logic [XLEN-1:0] src2;
	logic [XLEN-1:0] pc_plus4;
	ex_ctrl_t        nxt;

	assign pc_plus4 = pc + XLEN'(4);

	always_comb
	begin
		case (ctrl.src1_sel)
			SRC1_PC:   src1 = pc;
			SRC1_ZERO: src1 = '0;
			default:   src1 = rs1_data;
		endcase
		case (ctrl.src2_sel)
			SRC2_IMM: src2 = imm;
			SRC2_PC4: src2 = pc_plus4; // return address
			default:  src2 = rs2_data;
		endcase
	end

	always_comb
	begin
		nxt.alu_op = ctrl.alu_op;
		nxt.branch_op = ctrl.branch_op;
		nxt.mem = ctrl.mem;
		nxt.jalr = ctrl.jalr;
		nxt.rd = rd;
		nxt.rd_we = ctrl.rd_we;
		nxt.src1 = src1;
		nxt.src2 = src2;
		nxt.store_data = rs2_data;
		nxt.imm = imm;
		nxt.pc = pc;
	end

	// turn a slot into a bubble without touching its data
	function automatic ex_ctrl_t kill_ctrl(input ex_ctrl_t c);
		ex_ctrl_t k;

		k = c;
		k.alu_op = ALU_NONE;
		k.branch_op = BR_NONE;
		k.mem = '0;
		k.jalr = 1'b0;
		k.rd_we = 1'b0;
		return k;
	endfunction

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			dec_valid <= 1'b0;
			ex_ctrl <= '0;
		end
		else if (flush)
		begin
			dec_valid <= 1'b0;
			ex_ctrl <= kill_ctrl(ex_ctrl);
		end
		else if (ex_ready) // transfer, otherwise hold
		begin
			dec_valid <= if_valid;
			ex_ctrl <= if_valid ? nxt : kill_ctrl(ex_ctrl);
		end
	end

endmodule

// ==== src/rv_isa_pkg.sv ====
/*
 RV32I opcodes and instruction word layouts used by the decode stage.
 system, fence and RV32M encodings are not listed and decode as unknown.
*/

package rv_isa_pkg;

	localparam int XLEN = 32;

	typedef logic [4:0] reg_idx_t;

	// only the opcodes the stage still decodes
	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_BRANCH = 7'b1100011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_ALU_IR = 7'b0010011,
		OP_ALU_RR = 7'b0110011
	} opcode_e;

	localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
	localparam logic [6:0] FUNCT7_ALT  = 7'b0100000; // sub, sra

	// funct3 of the ALU group
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101; // srl or sra by funct7
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	// funct3 of the branch group
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	typedef struct packed {
		logic [6:0] funct7;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		reg_idx_t   rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		reg_idx_t    rs1;
		logic [2:0]  funct3;
		reg_idx_t    rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		reg_idx_t    rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		reg_idx_t   rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// one fetched word, seen through whichever layout its opcode implies
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} instr_u;

endpackage
